/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/100ps -j 0
TOP       = tb_dw_upsizer
FILELIST  = verilog.f
BUILD_DIR = obj_dir
PASS_MSG  = Finished with no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# Passes only when the pass line shows up in the simulation output
run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* hw/axi_cfg_pkg.sv */
// ********************
// AXI upsizer configuration
// Bus widths of the narrow and wide sides and the
// constants derived from them
// ********************
`default_nettype none

package axi_cfg_pkg;

  localparam int addr_width      = 32;
  localparam int nar_data_width  = 32;
  localparam int wide_data_width = 64;
  localparam int id_width        = 4;

  // Byte lanes per bus
  localparam int nar_strb_width  = nar_data_width / 8;
  localparam int wide_strb_width = wide_data_width / 8;

  // AxSIZE of a full narrow beat and of a full wide beat
  localparam int nar_size  = $clog2(nar_strb_width);
  localparam int wide_size = $clog2(wide_strb_width);

  // Modifiable bit within AxCACHE
  localparam int cache_modifiable = 1;

endpackage

`default_nettype wire

/* hw/axi_chan_pkg.sv */
// ********************
// AXI channel types
// Channel payload structs, burst and response codes,
// and the engine state shared by both paths
// ********************
`default_nettype none

package axi_chan_pkg;
  import axi_cfg_pkg::*;

  typedef logic [addr_width-1:0] addr_t;
  typedef logic [id_width-1:0]   id_t;
  typedef logic [7:0]            len_t;
  typedef logic [2:0]            size_t;

  typedef enum logic [1:0] {FIXED, INCR, WRAP} burst_e;
  typedef enum logic [1:0] {OKAY, EXOKAY, SLVERR, DECERR} resp_e;

  // Engine state, same for the write and the read path
  typedef enum logic [1:0] {IDLE, PASSTHROUGH, INCR_UPSIZE} upsize_state_e;

  typedef struct packed {
    id_t        id;
    addr_t      addr;
    len_t       len;
    size_t      size;
    burst_e     burst;
    logic [3:0] cache;
  } ax_chan_t;

  typedef struct packed {
    logic [nar_data_width-1:0] data;
    logic [nar_strb_width-1:0] strb;
    logic                      last;
  } nar_w_t;

  typedef struct packed {
    logic [wide_data_width-1:0] data;
    logic [wide_strb_width-1:0] strb;
    logic                       last;
  } wide_w_t;

  typedef struct packed {
    id_t   id;
    resp_e resp;
  } b_chan_t;

  typedef struct packed {
    id_t                       id;
    logic [nar_data_width-1:0] data;
    resp_e                     resp;
    logic                      last;
  } nar_r_t;

  typedef struct packed {
    id_t                        id;
    logic [wide_data_width-1:0] data;
    resp_e                      resp;
    logic                       last;
  } wide_r_t;

  // Address of the beat after addr within a burst
  function automatic addr_t beat_next_addr(addr_t addr, size_t size, len_t len, burst_e burst);
    addr_t size_mask;
    addr_t wrap_mask;
    addr_t incr_addr;
    size_mask = (addr_t'(1) << size) - addr_t'(1);
    wrap_mask = ((addr_t'(len) + addr_t'(1)) << size) - addr_t'(1);
    incr_addr = (addr & ~size_mask) + (addr_t'(1) << size);
    case (burst)
      FIXED:   return addr;
      WRAP:    return (addr & ~wrap_mask) | (incr_addr & wrap_mask);
      default: return incr_addr;
    endcase
  endfunction

endpackage

`default_nettype wire

/* hw/dw_burst_planner.sv */
// ********************
// Burst planner
// Turns a modifiable INCR burst into full-width beats,
// passes every other burst through unchanged
// ********************
`timescale 1ns/100ps
`default_nettype none

module dw_burst_planner
  import axi_cfg_pkg::*, axi_chan_pkg::*;
(
  input  ax_chan_t req_i,
  output ax_chan_t req_o,
  output logic     upsize_o
);

  addr_t size_mask;
  addr_t last_addr;
  addr_t word_span;

  always_comb begin
    size_mask = (addr_t'(1) << req_i.size) - addr_t'(1);
    // Address of the final narrow beat, first beat aligned down to its size
    last_addr = (req_i.addr & ~size_mask) + (addr_t'(req_i.len) << req_i.size);
    // Wide words touched, minus one
    word_span = (last_addr >> wide_size) - (req_i.addr >> wide_size);

    upsize_o = (req_i.burst == INCR) && req_i.cache[cache_modifiable];

    req_o = req_i;
    if (upsize_o) begin
      req_o.len  = len_t'(word_span);
      req_o.size = size_t'(wide_size);
    end
  end

endmodule

`default_nettype wire

/* hw/dw_read_unpacker.sv */
// ********************
// Read engine of the upsizer
// Issues the wide AR for one read at a time and splits
// wide R words into narrow beats
// ********************
`timescale 1ns/100ps
`default_nettype none

module dw_read_unpacker
  import axi_cfg_pkg::*, axi_chan_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  ax_chan_t nar_ar_i,
  input  logic     nar_ar_valid_i,
  output logic     nar_ar_ready_o,
  output nar_r_t   nar_r_o,
  output logic     nar_r_valid_o,
  input  logic     nar_r_ready_i,
  output ax_chan_t wide_ar_o,
  output logic     wide_ar_valid_o,
  input  logic     wide_ar_ready_i,
  input  wide_r_t  wide_r_i,
  input  logic     wide_r_valid_i,
  output logic     wide_r_ready_o
);

  upsize_state_e state_q, state_d;
  ax_chan_t      plan_ar;
  logic          plan_upsize;
  ax_chan_t      ar_q, ar_d;
  logic          ar_valid_q, ar_valid_d;
  addr_t         addr_q, addr_d;
  len_t          len_q, len_d;
  size_t         size_q, size_d;
  logic          r_active;
  logic          nar_hs;
  addr_t         next_addr;
  logic          word_done;
  int            nar_off;
  int            wide_off;
  int            beat_bytes;

  dw_burst_planner u_planner (
    .req_i    (nar_ar_i),
    .req_o    (plan_ar),
    .upsize_o (plan_upsize)
  );

  assign nar_ar_ready_o  = (state_q == IDLE);
  assign wide_ar_o       = ar_q;
  assign wide_ar_valid_o = ar_valid_q;

  // R flows only once the wide AR is out
  assign r_active       = (state_q != IDLE) && !ar_valid_q;
  assign nar_r_valid_o  = r_active && wide_r_valid_i;
  assign nar_hs         = nar_r_valid_o && nar_r_ready_i;
  assign wide_r_ready_o = nar_hs && word_done;

  assign nar_off    = int'(addr_q[nar_size-1:0]);
  assign wide_off   = int'(addr_q[wide_size-1:0]);
  assign beat_bytes = 1 << size_q;
  assign next_addr  = beat_next_addr(addr_q, size_q, ar_q.len, ar_q.burst);
  assign word_done  = (state_q == PASSTHROUGH) || (len_q == '0) ||
                      (next_addr[addr_width-1:wide_size] != addr_q[addr_width-1:wide_size]);

  // Pick this beat's bytes out of the current wide word
  always_comb begin
    nar_r_o      = '0;
    nar_r_o.id   = wide_r_i.id;
    nar_r_o.resp = wide_r_i.resp;
    nar_r_o.last = (len_q == '0);
    for (int b = 0; b < nar_strb_width; b++) begin
      if (b >= nar_off && b - nar_off < beat_bytes) begin
        nar_r_o.data[8*b +: 8] = wide_r_i.data[8*(b + wide_off - nar_off) +: 8];
      end
    end
  end

  always_comb begin
    state_d    = state_q;
    ar_d       = ar_q;
    ar_valid_d = ar_valid_q;
    addr_d     = addr_q;
    len_d      = len_q;
    size_d     = size_q;

    if (ar_valid_q && wide_ar_ready_i) begin
      ar_valid_d = 1'b0;
    end

    if (nar_hs) begin
      addr_d = next_addr;
      len_d  = len_q - 1'b1;
      if (len_q == '0) begin
        state_d = IDLE;
      end
    end

    if (nar_ar_valid_i && nar_ar_ready_o) begin
      ar_d       = plan_ar;
      ar_valid_d = 1'b1;
      addr_d     = nar_ar_i.addr;
      len_d      = nar_ar_i.len;
      size_d     = nar_ar_i.size;
      state_d    = plan_upsize ? INCR_UPSIZE : PASSTHROUGH;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= IDLE;
      ar_valid_q <= 1'b0;
      addr_q     <= '0;
      len_q      <= '0;
      size_q     <= '0;
    end else begin
      state_q    <= state_d;
      ar_valid_q <= ar_valid_d;
      addr_q     <= addr_d;
      len_q      <= len_d;
      size_q     <= size_d;
    end
  end

  always_ff @(posedge clk_i) begin
    ar_q <= ar_d;
  end

  a_ar_size_fits: assert property (@(posedge clk_i) disable iff (!rst_ni)
    nar_ar_valid_i && nar_ar_ready_o |-> nar_ar_i.size <= size_t'(nar_size))
    else $error("AR size exceeds the narrow bus");

  // Wide last arrives with the word that holds the final narrow beat
  a_r_last_match: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wide_r_valid_i && wide_r_ready_o |-> wide_r_i.last == nar_r_o.last)
    else $error("wide R last does not match the end of the narrow burst");

endmodule

`default_nettype wire

/* hw/dw_upsizer_top.sv */
// ********************
// AXI data-width upsizer, 32-bit manager to 64-bit
// subordinate, one write engine and one read engine
// ********************
`timescale 1ns/100ps
`default_nettype none

module dw_upsizer_top
  import axi_chan_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  // Narrow side
  input  ax_chan_t nar_aw_i,
  input  logic     nar_aw_valid_i,
  output logic     nar_aw_ready_o,
  input  nar_w_t   nar_w_i,
  input  logic     nar_w_valid_i,
  output logic     nar_w_ready_o,
  output b_chan_t  nar_b_o,
  output logic     nar_b_valid_o,
  input  logic     nar_b_ready_i,
  input  ax_chan_t nar_ar_i,
  input  logic     nar_ar_valid_i,
  output logic     nar_ar_ready_o,
  output nar_r_t   nar_r_o,
  output logic     nar_r_valid_o,
  input  logic     nar_r_ready_i,
  // Wide side
  output ax_chan_t wide_aw_o,
  output logic     wide_aw_valid_o,
  input  logic     wide_aw_ready_i,
  output wide_w_t  wide_w_o,
  output logic     wide_w_valid_o,
  input  logic     wide_w_ready_i,
  input  b_chan_t  wide_b_i,
  input  logic     wide_b_valid_i,
  output logic     wide_b_ready_o,
  output ax_chan_t wide_ar_o,
  output logic     wide_ar_valid_o,
  input  logic     wide_ar_ready_i,
  input  wide_r_t  wide_r_i,
  input  logic     wide_r_valid_i,
  output logic     wide_r_ready_o
);

  // Engine port names match the top, so both connect by name
  dw_write_packer u_write (.*);

  dw_read_unpacker u_read (.*);

endmodule

`default_nettype wire

/* hw/dw_write_packer.sv */
// ********************
// Write engine of the upsizer
// Registers the planned AW, packs narrow W beats into
// wide words and forwards B straight through
// ********************
`timescale 1ns/100ps
`default_nettype none

module dw_write_packer
  import axi_cfg_pkg::*, axi_chan_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  ax_chan_t nar_aw_i,
  input  logic     nar_aw_valid_i,
  output logic     nar_aw_ready_o,
  input  nar_w_t   nar_w_i,
  input  logic     nar_w_valid_i,
  output logic     nar_w_ready_o,
  output b_chan_t  nar_b_o,
  output logic     nar_b_valid_o,
  input  logic     nar_b_ready_i,
  output ax_chan_t wide_aw_o,
  output logic     wide_aw_valid_o,
  input  logic     wide_aw_ready_i,
  output wide_w_t  wide_w_o,
  output logic     wide_w_valid_o,
  input  logic     wide_w_ready_i,
  input  b_chan_t  wide_b_i,
  input  logic     wide_b_valid_i,
  output logic     wide_b_ready_o
);

  upsize_state_e state_q, state_d;
  ax_chan_t      plan_aw;
  logic          plan_upsize;
  ax_chan_t      aw_q, aw_d;
  logic          aw_valid_q, aw_valid_d;
  addr_t         addr_q, addr_d;
  len_t          len_q, len_d;
  size_t         size_q, size_d;
  wide_w_t       w_q, w_d;
  logic          w_valid_q, w_valid_d;
  // Final narrow beat already packed
  logic          in_done_q, in_done_d;
  addr_t         next_addr;
  logic          word_done;
  int            nar_off;
  int            wide_off;
  int            beat_bytes;

  dw_burst_planner u_planner (
    .req_i    (nar_aw_i),
    .req_o    (plan_aw),
    .upsize_o (plan_upsize)
  );

  assign nar_aw_ready_o  = (state_q == IDLE);
  assign nar_w_ready_o   = (state_q != IDLE) && !aw_valid_q && !in_done_q &&
                           (!w_valid_q || wide_w_ready_i);
  assign wide_aw_o       = aw_q;
  assign wide_aw_valid_o = aw_valid_q;
  assign wide_w_o        = w_q;
  assign wide_w_valid_o  = w_valid_q;

  // B needs no conversion
  assign nar_b_o        = wide_b_i;
  assign nar_b_valid_o  = wide_b_valid_i;
  assign wide_b_ready_o = nar_b_ready_i;

  assign nar_off    = int'(addr_q[nar_size-1:0]);
  assign wide_off   = int'(addr_q[wide_size-1:0]);
  assign beat_bytes = 1 << size_q;
  assign next_addr  = beat_next_addr(addr_q, size_q, aw_q.len, aw_q.burst);
  // Word is full once the next beat leaves it
  assign word_done  = (state_q == PASSTHROUGH) || (len_q == '0) ||
                      (next_addr[addr_width-1:wide_size] != addr_q[addr_width-1:wide_size]);

  always_comb begin
    state_d    = state_q;
    aw_d       = aw_q;
    aw_valid_d = aw_valid_q;
    addr_d     = addr_q;
    len_d      = len_q;
    size_d     = size_q;
    w_d        = w_q;
    w_valid_d  = w_valid_q;
    in_done_d  = in_done_q;

    if (aw_valid_q && wide_aw_ready_i) begin
      aw_valid_d = 1'b0;
    end

    if (w_valid_q && wide_w_ready_i) begin
      w_valid_d = 1'b0;
      w_d.strb  = '0;
      if (w_q.last) begin
        state_d = IDLE;
      end
    end

    if (nar_w_valid_i && nar_w_ready_o) begin
      // Lane steering into the wide word
      for (int b = 0; b < nar_strb_width; b++) begin
        if (b >= nar_off && b - nar_off < beat_bytes) begin
          w_d.data[8*(b + wide_off - nar_off) +: 8] = nar_w_i.data[8*b +: 8];
          w_d.strb[b + wide_off - nar_off]          = nar_w_i.strb[b];
        end
      end
      w_d.last = (len_q == '0);
      addr_d   = next_addr;
      len_d    = len_q - 1'b1;
      if (len_q == '0) begin
        in_done_d = 1'b1;
      end
      if (word_done) begin
        w_valid_d = 1'b1;
      end
    end

    if (nar_aw_valid_i && nar_aw_ready_o) begin
      aw_d       = plan_aw;
      aw_valid_d = 1'b1;
      addr_d     = nar_aw_i.addr;
      len_d      = nar_aw_i.len;
      size_d     = nar_aw_i.size;
      w_d.strb   = '0;
      in_done_d  = 1'b0;
      state_d    = plan_upsize ? INCR_UPSIZE : PASSTHROUGH;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= IDLE;
      aw_valid_q <= 1'b0;
      w_valid_q  <= 1'b0;
      in_done_q  <= 1'b0;
      addr_q     <= '0;
      len_q      <= '0;
      size_q     <= '0;
    end else begin
      state_q    <= state_d;
      aw_valid_q <= aw_valid_d;
      w_valid_q  <= w_valid_d;
      in_done_q  <= in_done_d;
      addr_q     <= addr_d;
      len_q      <= len_d;
      size_q     <= size_d;
    end
  end

  always_ff @(posedge clk_i) begin
    aw_q <= aw_d;
    w_q  <= w_d;
  end

  a_aw_size_fits: assert property (@(posedge clk_i) disable iff (!rst_ni)
    nar_aw_valid_i && nar_aw_ready_o |-> nar_aw_i.size <= size_t'(nar_size))
    else $error("AW size exceeds the narrow bus");

  // Manager's last flag agrees with the burst length from AW
  a_w_last_match: assert property (@(posedge clk_i) disable iff (!rst_ni)
    nar_w_valid_i && nar_w_ready_o |-> nar_w_i.last == (len_q == '0))
    else $error("narrow W last does not match AW length");

  a_wide_w_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wide_w_valid_o && !wide_w_ready_i |=> wide_w_valid_o && $stable(wide_w_o))
    else $error("wide W dropped or changed before ready");

endmodule

`default_nettype wire

/* tb/dw_upsizer_testdata.txt */
# op id addr len size burst mod exp_len exp_size exp_resp (all hex)
# op 1 = write then read back, op 0 = write only; burst 0 = FIXED, 1 = INCR
1 1 00001000 07 2 1 1 03 3 0
1 2 00001104 04 2 1 1 02 3 0
1 3 00001201 03 2 1 1 01 3 0
1 4 00001306 05 2 1 1 03 3 2
1 5 00001400 0b 0 1 1 01 3 0
1 6 00001503 06 0 1 1 01 3 0
1 7 00001602 07 1 1 1 02 3 0
1 8 00001700 00 2 1 1 00 3 1
1 9 00001804 00 2 1 1 00 3 0
1 a 00001900 0f 2 1 1 07 3 0
1 b 00001a00 03 2 1 0 03 2 0
1 c 00001b04 02 2 1 0 02 2 0
1 d 00001c01 02 2 1 0 02 2 2
1 e 00001d00 03 2 0 1 03 2 0
1 f 00001e04 02 2 0 1 02 2 0
1 0 00001f02 03 1 0 0 03 1 0
1 3 00002000 05 1 1 0 05 1 0
1 4 00002106 03 0 1 1 01 3 0
0 5 00002200 03 2 1 1 01 3 3
1 6 00002204 01 2 1 1 01 3 0
1 7 0000233c 00 2 1 1 00 3 0

/* tb/tb_dw_upsizer.sv */
// ********************
// Testbench for the AXI upsizer
// Narrow manager driver, wide memory model and
// checks against a byte-level reference memory
// ********************
`timescale 1ns/100ps
`default_nettype none

module tb_dw_upsizer
  import axi_cfg_pkg::*, axi_chan_pkg::*;
();

  localparam int max_tests = 64;

  logic     clk_i;
  logic     rst_ni;
  ax_chan_t nar_aw_i;
  logic     nar_aw_valid_i;
  logic     nar_aw_ready_o;
  nar_w_t   nar_w_i;
  logic     nar_w_valid_i;
  logic     nar_w_ready_o;
  b_chan_t  nar_b_o;
  logic     nar_b_valid_o;
  logic     nar_b_ready_i;
  ax_chan_t nar_ar_i;
  logic     nar_ar_valid_i;
  logic     nar_ar_ready_o;
  nar_r_t   nar_r_o;
  logic     nar_r_valid_o;
  logic     nar_r_ready_i;
  ax_chan_t wide_aw_o;
  logic     wide_aw_valid_o;
  logic     wide_aw_ready_i;
  wide_w_t  wide_w_o;
  logic     wide_w_valid_o;
  logic     wide_w_ready_i;
  b_chan_t  wide_b_i;
  logic     wide_b_valid_i;
  logic     wide_b_ready_o;
  ax_chan_t wide_ar_o;
  logic     wide_ar_valid_o;
  logic     wide_ar_ready_i;
  wide_r_t  wide_r_i;
  logic     wide_r_valid_i;
  logic     wide_r_ready_o;

  // Test table from the data file
  logic        t_op      [max_tests];
  logic [3:0]  t_id      [max_tests];
  logic [31:0] t_addr    [max_tests];
  logic [7:0]  t_len     [max_tests];
  logic [2:0]  t_size    [max_tests];
  logic [1:0]  t_burst   [max_tests];
  logic        t_mod     [max_tests];
  logic [7:0]  t_exp_len [max_tests];
  logic [2:0]  t_exp_size[max_tests];
  logic [1:0]  t_resp    [max_tests];

  int errors;
  int checks;
  int ntests;
  int cycles;
  int cycle_limit;
  logic [1:0] cur_resp;

  // Bytes as the manager wrote them, and bytes as they reached the wide side
  logic [7:0] expect_mem [logic [31:0]];
  logic [7:0] wide_mem   [logic [31:0]];

  // Wide memory model state
  ax_chan_t    cap_aw;
  ax_chan_t    cap_ar;
  logic [31:0] w_addr;
  logic [31:0] r_addr;
  int          wb_count;
  int          last_count;
  int          last_idx;
  int          r_idx;
  logic        b_due;
  logic        b_fire;
  logic        r_fire;
  logic        rd_active;

  dw_upsizer_top dut0 (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycle_limit > 0 && cycles > cycle_limit) begin
      $display("timeout: transaction did not complete");
      $display("Finished with errors");
      $finish;
    end
  end

  function automatic logic [7:0] fill_byte(input logic [31:0] a);
    return a[31:24] ^ a[23:16] ^ a[15:8] ^ a[7:0] ^ 8'ha5;
  endfunction

  function automatic logic [7:0] memory_byte(input logic [31:0] a);
    if (wide_mem.exists(a)) begin
      return wide_mem[a];
    end
    return fill_byte(a);
  endfunction

  // Narrow lanes of a beat from its address up to the end of its size container
  function automatic logic [3:0] lane_mask(input logic [31:0] a, input logic [2:0] size);
    logic [31:0] aligned;
    logic [3:0]  mask;
    int          lo;
    int          hi;
    aligned = a & ~((32'd1 << size) - 32'd1);
    lo      = int'(a[1:0]);
    hi      = int'(aligned[1:0]) + (1 << size) - 1;
    mask    = '0;
    for (int b = 0; b < 4; b++) begin
      if (b >= lo && b <= hi) begin
        mask[b] = 1'b1;
      end
    end
    return mask;
  endfunction

  function automatic logic [31:0] next_beat_addr(input logic [31:0] a, input logic [2:0] size,
                                                 input logic [1:0] burst);
    logic [31:0] sz;
    sz = 32'd1 << size;
    if (burst == 2'd0) begin
      return a;
    end
    return (a & ~(sz - 32'd1)) + sz;
  endfunction

  task automatic check_value(input logic [63:0] got, input logic [63:0] exp, input string msg);
    checks++;
    if (got !== exp) begin
      $display("mismatch at %0t: %s, got %0h expected %0h", $time, msg, got, exp);
      errors++;
    end
  endtask

  task automatic load_tests();
    int          fd;
    int          cnt;
    int          total;
    string       line;
    logic [31:0] v_op, v_id, v_addr, v_len, v_size;
    logic [31:0] v_burst, v_mod, v_elen, v_esize, v_resp;
    ntests = 0;
    total  = 0;
    fd = $fopen("tb/dw_upsizer_testdata.txt", "r");
    if (fd == 0) begin
      $display("cannot open the test data file tb/dw_upsizer_testdata.txt");
    end else begin
      while (!$feof(fd) && ntests < max_tests) begin
        cnt = $fgets(line, fd);
        if (cnt > 1 && line.getc(0) != "#") begin
          cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h", v_op, v_id, v_addr, v_len,
                        v_size, v_burst, v_mod, v_elen, v_esize, v_resp);
          if (cnt == 10) begin
            t_op[ntests]       = v_op[0];
            t_id[ntests]       = v_id[3:0];
            t_addr[ntests]     = v_addr;
            t_len[ntests]      = v_len[7:0];
            t_size[ntests]     = v_size[2:0];
            t_burst[ntests]    = v_burst[1:0];
            t_mod[ntests]      = v_mod[0];
            t_exp_len[ntests]  = v_elen[7:0];
            t_exp_size[ntests] = v_esize[2:0];
            t_resp[ntests]     = v_resp[1:0];
            total += (int'(v_len[7:0]) + 1) * (v_op[0] ? 2 : 1);
            ntests++;
          end else begin
            $display("malformed line in the test data file: %s", line);
            errors++;
          end
        end
      end
      $fclose(fd);
    end
    cycle_limit = 200 * total;
  endtask

  task automatic build_request(input int t, output ax_chan_t req);
    req       = '0;
    req.id    = t_id[t];
    req.addr  = t_addr[t];
    req.len   = t_len[t];
    req.size  = t_size[t];
    req.burst = burst_e'(t_burst[t]);
    req.cache[cache_modifiable] = t_mod[t];
  endtask

  task automatic write_burst(input int t);
    logic [31:0] a;
    logic [31:0] data;
    logic [3:0]  mask;
    ax_chan_t    req;
    build_request(t, req);
    nar_aw_i       = req;
    nar_aw_valid_i = 1'b1;
    cur_resp       = t_resp[t];
    #10;
    while (!nar_aw_ready_o) begin
      @(negedge clk_i);
      #10;
    end
    @(negedge clk_i);
    nar_aw_valid_i = 1'b0;
    a = t_addr[t];
    for (int i = 0; i <= int'(t_len[t]); i++) begin
      mask = lane_mask(a, t_size[t]);
      data = $urandom;
      nar_w_i.data  = data;
      nar_w_i.strb  = mask;
      nar_w_i.last  = (i == int'(t_len[t]));
      nar_w_valid_i = 1'b1;
      for (int b = 0; b < 4; b++) begin
        if (mask[b]) begin
          expect_mem[{a[31:2], 2'b00} + 32'(b)] = data[8*b +: 8];
        end
      end
      #10;
      while (!nar_w_ready_o) begin
        @(negedge clk_i);
        #10;
      end
      @(negedge clk_i);
      a = next_beat_addr(a, t_size[t], t_burst[t]);
    end
    nar_w_valid_i = 1'b0;
    #10;
    while (!nar_b_valid_o) begin
      @(negedge clk_i);
      #10;
    end
    check_value(64'(nar_b_o.id), 64'(t_id[t]), "B id");
    check_value(64'(nar_b_o.resp), 64'(t_resp[t]), "B resp");
    check_value(64'(cap_aw.addr), 64'(t_addr[t]), "wide AW addr");
    check_value(64'(cap_aw.len), 64'(t_exp_len[t]), "wide AW len");
    check_value(64'(cap_aw.size), 64'(t_exp_size[t]), "wide AW size");
    check_value(64'(wb_count), 64'(int'(t_exp_len[t]) + 1), "wide W beat count");
    check_value(64'(last_count), 64'd1, "wide W last flags");
    check_value(64'(last_idx), 64'(t_exp_len[t]), "wide W last position");
    @(negedge clk_i);
  endtask

  task automatic read_back(input int t);
    logic [31:0] a;
    logic [3:0]  mask;
    ax_chan_t    req;
    build_request(t, req);
    nar_ar_i       = req;
    nar_ar_valid_i = 1'b1;
    #10;
    while (!nar_ar_ready_o) begin
      @(negedge clk_i);
      #10;
    end
    @(negedge clk_i);
    nar_ar_valid_i = 1'b0;
    a = t_addr[t];
    for (int i = 0; i <= int'(t_len[t]); i++) begin
      #10;
      while (!nar_r_valid_o) begin
        @(negedge clk_i);
        #10;
      end
      mask = lane_mask(a, t_size[t]);
      for (int b = 0; b < 4; b++) begin
        if (mask[b]) begin
          check_value(64'(nar_r_o.data[8*b +: 8]),
                      64'(expect_mem[{a[31:2], 2'b00} + 32'(b)]),
                      $sformatf("read byte at %08h", {a[31:2], 2'b00} + 32'(b)));
        end
      end
      check_value(64'(nar_r_o.last), 64'(i == int'(t_len[t])), "R last");
      check_value(64'(nar_r_o.resp), 64'(t_resp[t]), "R resp");
      check_value(64'(nar_r_o.id), 64'(t_id[t]), "R id");
      @(negedge clk_i);
      a = next_beat_addr(a, t_size[t], t_burst[t]);
    end
    check_value(64'(cap_ar.len), 64'(t_exp_len[t]), "wide AR len");
    check_value(64'(cap_ar.size), 64'(t_exp_size[t]), "wide AR size");
  endtask

  // Wide memory model driving at the falling edge and sampling 10 ns later
  initial begin
    b_due     = 1'b0;
    b_fire    = 1'b0;
    r_fire    = 1'b0;
    rd_active = 1'b0;
    wb_count  = 0;
    last_idx  = -1;
    wait (rst_ni === 1'b1);
    forever begin
      @(negedge clk_i);
      wide_aw_ready_i = ($urandom % 4) != 0;
      wide_w_ready_i  = ($urandom % 3) != 0;
      wide_ar_ready_i = ($urandom % 4) != 0;
      if (b_fire) begin
        wide_b_valid_i = 1'b0;
      end
      if (b_due && !wide_b_valid_i) begin
        wide_b_i.id    = cap_aw.id;
        wide_b_i.resp  = resp_e'(cur_resp);
        wide_b_valid_i = 1'b1;
        b_due          = 1'b0;
      end
      if (r_fire) begin
        wide_r_valid_i = 1'b0;
      end
      if (rd_active && !wide_r_valid_i && ($urandom % 3) != 0) begin
        wide_r_i.id   = cap_ar.id;
        wide_r_i.resp = resp_e'(cur_resp);
        wide_r_i.last = (r_idx == int'(cap_ar.len));
        for (int l = 0; l < 8; l++) begin
          wide_r_i.data[8*l +: 8] = memory_byte({r_addr[31:3], 3'b000} + 32'(l));
        end
        wide_r_valid_i = 1'b1;
      end
      #10;
      b_fire = wide_b_valid_i && wide_b_ready_o;
      r_fire = wide_r_valid_i && wide_r_ready_o;
      if (wide_aw_valid_o && wide_aw_ready_i) begin
        cap_aw     = wide_aw_o;
        w_addr     = wide_aw_o.addr;
        wb_count   = 0;
        last_count = 0;
        last_idx   = -1;
      end
      if (wide_w_valid_o && wide_w_ready_i) begin
        for (int l = 0; l < 8; l++) begin
          if (wide_w_o.strb[l]) begin
            wide_mem[{w_addr[31:3], 3'b000} + 32'(l)] = wide_w_o.data[8*l +: 8];
          end
        end
        if (wide_w_o.last) begin
          last_count++;
          last_idx = wb_count;
          b_due    = 1'b1;
        end
        wb_count++;
        w_addr = next_beat_addr(w_addr, cap_aw.size, cap_aw.burst);
      end
      if (wide_ar_valid_o && wide_ar_ready_i) begin
        cap_ar    = wide_ar_o;
        r_addr    = wide_ar_o.addr;
        r_idx     = 0;
        rd_active = 1'b1;
      end
      if (r_fire) begin
        r_addr = next_beat_addr(r_addr, cap_ar.size, cap_ar.burst);
        r_idx++;
        if (r_idx > int'(cap_ar.len)) begin
          rd_active = 1'b0;
        end
      end
    end
  end

  initial begin
    int errs_before;
    void'($urandom(25892));
    errors          = 0;
    checks          = 0;
    cycles          = 0;
    cycle_limit     = 0;
    cur_resp        = '0;
    rst_ni          = 1'b0;
    nar_aw_i        = '0;
    nar_aw_valid_i  = 1'b0;
    nar_w_i         = '0;
    nar_w_valid_i   = 1'b0;
    nar_b_ready_i   = 1'b1;
    nar_ar_i        = '0;
    nar_ar_valid_i  = 1'b0;
    nar_r_ready_i   = 1'b1;
    wide_aw_ready_i = 1'b0;
    wide_w_ready_i  = 1'b0;
    wide_b_i        = '0;
    wide_b_valid_i  = 1'b0;
    wide_ar_ready_i = 1'b0;
    wide_r_i        = '0;
    wide_r_valid_i  = 1'b0;
    load_tests();
    if (ntests == 0) begin
      $display("no test could be read from the test data file");
      errors++;
    end else begin
      repeat (8) @(negedge clk_i);
      rst_ni = 1'b1;
      #10;
      check_value(64'(wide_aw_valid_o), 64'd0, "wide AW valid after reset");
      check_value(64'(wide_w_valid_o), 64'd0, "wide W valid after reset");
      check_value(64'(wide_ar_valid_o), 64'd0, "wide AR valid after reset");
      check_value(64'(nar_r_valid_o), 64'd0, "narrow R valid after reset");
      check_value(64'(nar_aw_ready_o), 64'd1, "AW ready after reset");
      check_value(64'(nar_ar_ready_o), 64'd1, "AR ready after reset");
      $display("test reset: %s", (errors == 0) ? "pass" : "fail");
      @(negedge clk_i);
      for (int t = 0; t < ntests; t++) begin
        errs_before = errors;
        write_burst(t);
        if (t_op[t]) begin
          read_back(t);
        end
        $display("test %0d %s id %0h addr %08h len %0d size %0d burst %0d: %s", t,
                 t_op[t] ? "write+read" : "write", t_id[t], t_addr[t], t_len[t], t_size[t],
                 t_burst[t], (errors == errs_before) ? "pass" : "fail");
      end
    end
    $display("%0d tests, %0d checks, %0d errors", ntests, checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
hw/axi_cfg_pkg.sv
hw/axi_chan_pkg.sv
hw/dw_burst_planner.sv
hw/dw_write_packer.sv
hw/dw_read_unpacker.sv
hw/dw_upsizer_top.sv
tb/tb_dw_upsizer.sv
